//--- Bender.yml
package:
  name: video_subsys

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/cpu_bus_if.sv
      - hdl/raster_if.sv
      - hdl/video_timing.sv
      - hdl/video_regs.sv
      - hdl/tile_layer.sv
      - hdl/colour_mixer.sv
      - hdl/video_top.sv
  - target: test
    files:
      - dv/video_props.sv
      - dv/video_tb.sv

//--- dv/video_props.sv
// Timing generator properties
// Sync inside blanking, single-clock vint, line interrupt on its line
`timescale 1ns/1ps
`default_nettype none

module video_props (
    input wire logic                         clk,
    input wire logic                         rst,
    input wire logic                         hs,
    input wire logic                         vs,
    input wire logic                         lhbl,
    input wire logic                         lvbl,
    input wire logic                         vint,
    input wire logic                         line_intn,
    input wire logic [video_pkg::v_bits-1:0] vcount,
    input wire logic [video_pkg::v_bits-1:0] int_line
);

    int assert_errors = 0;

    vint_single: assert property (@(posedge clk) disable iff (rst) vint |=> !vint)
        else begin
            assert_errors++;
            $error("vint high for more than one clock");
        end

    hs_in_hblank: assert property (@(posedge clk) disable iff (rst) hs |-> !lhbl)
        else begin
            assert_errors++;
            $error("hs high during active line");
        end

    vs_in_vblank: assert property (@(posedge clk) disable iff (rst) vs |-> !lvbl)
        else begin
            assert_errors++;
            $error("vs high during active frame");
        end

    // Skip the clock right after int_line is rewritten
    line_match: assert property (@(posedge clk) disable iff (rst)
        !line_intn && $stable(int_line) |-> vcount == int_line)
        else begin
            assert_errors++;
            $error("line_intn low away from int_line");
        end

endmodule

bind video_timing video_props props_i (
    .clk       ( clk            ),
    .rst       ( rst            ),
    .hs        ( hs             ),
    .vs        ( vs             ),
    .lhbl      ( raster.lhbl    ),
    .lvbl      ( raster.lvbl    ),
    .vint      ( vint           ),
    .line_intn ( line_intn      ),
    .vcount    ( raster.vcount  ),
    .int_line  ( int_line       )
);

`default_nettype wire

//--- dv/video_tb.sv
// Video subsystem testbench
// Table of bus writes and pixel probes, expected colours from a
// reference model of the mixer rule, plus reset and interrupt checks
`timescale 1ns/1ps
`default_nettype none

module video_tb;

    // Probe expectation packs {lhbl, lvbl, rgb}
    typedef struct packed {
        logic        probe;
        logic [1:0]  region;
        logic [5:0]  offset;
        logic [15:0] data;
        logic [5:0]  x;
        logic [4:0]  y;
        logic [16:0] expected;
    } step_t;

    logic        clk;
    logic        rst;
    logic [7:0]  cpu_addr;
    logic [15:0] cpu_data;
    logic        cpu_we;
    logic        hs;
    logic        vs;
    logic        lhbl;
    logic        lvbl;
    logic [5:0]  hdump;
    logic [4:0]  vdump;
    logic        vint;
    logic        line_intn;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;

    localparam int frame_clocks = video_pkg::h_total * video_pkg::v_total;

    step_t       steps[$];
    string       step_names[$];
    int unsigned lcg_state = 198;
    int          passes = 0;
    int          errors = 0;

    // Reference state mirrored from the table writes
    logic [14:0] pal_model [video_pkg::pal_entries];
    logic [4:0]  map_model [video_pkg::map_entries];
    logic        ctrl_model;
    logic [5:0]  scroll_model;
    logic [14:0] bg_model;

    video_top dut_i (
        .clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we),
        .hs(hs), .vs(vs), .lhbl(lhbl), .lvbl(lvbl), .hdump(hdump), .vdump(vdump),
        .vint(vint), .line_intn(line_intn), .red(red), .green(green), .blue(blue)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Mixer rule applied to the mirrored state
    function automatic logic [14:0] expected_colour(input int x, input int y);
        int          hpos;
        logic [4:0]  entry;
        if (x >= video_pkg::h_active || y >= video_pkg::v_active)
            return '0;
        hpos  = (x + scroll_model) % (video_pkg::map_cols * video_pkg::tile_size);
        entry = map_model[(y / video_pkg::tile_size) * video_pkg::map_cols
                          + hpos / video_pkg::tile_size];
        if (ctrl_model && entry[4])
            return pal_model[entry[3:0]];
        return bg_model;
    endfunction

    function automatic void add_write(input logic [1:0] region, input int offset,
                                      input logic [15:0] data);
        step_t s;
        s = '0;
        s.region = region;
        s.offset = 6'(offset);
        s.data   = data;
        if (region == video_pkg::region_palette && offset < video_pkg::pal_entries)
            pal_model[offset] = data[14:0];
        if (region == video_pkg::region_map && offset < video_pkg::map_entries)
            map_model[offset] = data[4:0];
        if (region == video_pkg::region_regs) begin
            case (offset)
                video_pkg::reg_ctrl:   ctrl_model   = data[0];
                video_pkg::reg_scroll: scroll_model = data[5:0];
                video_pkg::reg_bg:     bg_model     = data[14:0];
                default: ;
            endcase
        end
        steps.push_back(s);
        step_names.push_back("");
    endfunction

    function automatic void add_probe(input string tag, input int x, input int y);
        step_t s;
        s = '0;
        s.probe    = 1'b1;
        s.x        = 6'(x);
        s.y        = 5'(y);
        s.expected = {x < video_pkg::h_active, y < video_pkg::v_active,
                      expected_colour(x, y)};
        steps.push_back(s);
        step_names.push_back($sformatf("%s_x%0d_y%0d", tag, x, y));
    endfunction

    function automatic void build_table();
        foreach (pal_model[i]) pal_model[i] = '0;
        foreach (map_model[i]) map_model[i] = '0;
        ctrl_model   = 1'b0;
        scroll_model = '0;
        bg_model     = '0;
        // Random palette and a fully opaque map
        for (int i = 0; i < video_pkg::pal_entries; i++)
            add_write(video_pkg::region_palette, i, lcg_next() & 16'h7fff);
        for (int i = 0; i < video_pkg::map_entries; i++)
            add_write(video_pkg::region_map, i, 16'h0010 | (lcg_next() & 16'h000f));
        add_write(video_pkg::region_regs, video_pkg::reg_bg, lcg_next() | 16'h0001);
        add_write(video_pkg::region_regs, video_pkg::reg_ctrl, 16'h0001);
        add_probe("opaque", 0, 0);
        add_probe("opaque", 9, 0);
        add_probe("opaque", 17, 8);
        add_probe("opaque", 12, 15);
        add_probe("opaque", 25, 20);
        add_probe("opaque", 31, 23);
        // Transparent entries fall through to background
        add_write(video_pkg::region_map, 10, lcg_next() & 16'h000f);
        add_write(video_pkg::region_map, 0, lcg_next() & 16'h000f);
        add_probe("transparent", 18, 10);
        add_probe("transparent", 3, 2);
        add_probe("neighbour", 25, 10);
        // Layer off probes sit on opaque tiles
        add_write(video_pkg::region_regs, video_pkg::reg_ctrl, 16'h0000);
        add_probe("layer_off", 13, 5);
        add_probe("layer_off", 28, 12);
        add_probe("layer_off", 30, 22);
        // Scroll of 44 wraps from column 7 to column 0 at x 20
        add_write(video_pkg::region_regs, video_pkg::reg_ctrl, 16'h0001);
        add_write(video_pkg::region_regs, video_pkg::reg_scroll, 16'd44);
        add_probe("scroll", 3, 4);
        add_probe("scroll", 19, 4);
        add_probe("scroll", 20, 4);
        add_probe("scroll", 27, 17);
        add_probe("blank", 32, 5);
        add_probe("blank", 39, 10);
        add_probe("blank", 5, 24);
        add_probe("blank", 20, 27);
    endfunction

    task automatic bus_write(input logic [1:0] region, input logic [5:0] offset,
                             input logic [15:0] data);
        @(negedge clk);
        cpu_addr = {region, offset};
        cpu_data = data;
        cpu_we   = 1'b1;
        @(negedge clk);
        cpu_we   = 1'b0;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
        end else begin
            $display("ok    %s", name);
            passes++;
        end
    endtask

    // Let the pipeline settle and allow up to two frames to reach the position
    task automatic wait_position(input int x, input int y, output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        repeat (3) @(negedge clk);
        while (!found && cycles < 2 * frame_clocks) begin
            if (hdump == x && vdump == y) begin
                found = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!found) begin
            $display("Timed out waiting for pixel x=%0d y=%0d", x, y);
            errors++;
        end
    endtask

    task automatic count_frame_events(output int vint_pulses, output int intn_low,
                                      output int hs_high, output int vs_high);
        vint_pulses = 0;
        intn_low    = 0;
        hs_high     = 0;
        vs_high     = 0;
        for (int i = 0; i < frame_clocks; i++) begin
            @(negedge clk);
            if (vint) vint_pulses++;
            if (!line_intn) intn_low++;
            if (hs) hs_high++;
            if (vs) vs_high++;
        end
    endtask

    initial begin
        bit found;
        int vint_pulses;
        int intn_low;
        int hs_high;
        int vs_high;
        int assert_fails;
        cpu_addr = '0;
        cpu_data = '0;
        cpu_we   = 1'b0;
        rst      = 1'b1;
        repeat (3) @(negedge clk);
        check("reset_line_intn", 1, line_intn);
        check("reset_vint", 0, vint);
        check("reset_rgb_black", 0, {red, green, blue});
        rst = 1'b0;
        @(negedge clk);
        // int_line resets to 0, so line 0 interrupts at once
        check("line0_intn_low", 0, line_intn);

        build_table();
        foreach (steps[i]) begin
            if (steps[i].probe) begin
                wait_position(steps[i].x, steps[i].y, found);
                if (found)
                    check(step_names[i], steps[i].expected, {lhbl, lvbl, red, green, blue});
            end else begin
                bus_write(steps[i].region, steps[i].offset, steps[i].data);
            end
        end

        // Line interrupt at line 10 leads vdump by 2 clocks
        bus_write(video_pkg::region_regs, video_pkg::reg_line, 16'd10);
        wait_position(0, 10, found);
        if (found) begin
            check("line_intn_at_line", 0, line_intn);
            count_frame_events(vint_pulses, intn_low, hs_high, vs_high);
            check("vint_per_frame", 1, vint_pulses);
            check("line_intn_one_line", video_pkg::h_total, intn_low);
            check("hs_per_frame",
                  (video_pkg::h_sync_end - video_pkg::h_sync_start) * video_pkg::v_total,
                  hs_high);
            check("vs_per_frame",
                  (video_pkg::v_sync_end - video_pkg::v_sync_start) * video_pkg::h_total,
                  vs_high);
        end

        assert_fails = dut_i.u_timing.props_i.assert_errors;
        $display("Checks: %0d passed, %0d failed, %0d assertion failures",
                 passes, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/colour_mixer.sv
// Colour mixer
// Palette RAM, tile layer over background colour, and RGB blanking.
// Raster signals are delayed two clocks to stay aligned with the colour.
`timescale 1ns/1ps
`default_nettype none

module colour_mixer (
    input  logic                         clk,
    input  logic                         rst,
    cpu_bus_if.receiver                  bus,
    raster_if.sink                       raster,
    input  video_pkg::map_entry_t        tile_pxl,
    input  video_pkg::rgb_t              bg_colour,
    output logic [video_pkg::h_bits-1:0] hdump,
    output logic [video_pkg::v_bits-1:0] vdump,
    output logic                         lhbl,
    output logic                         lvbl,
    output logic [4:0]                   red,
    output logic [4:0]                   green,
    output logic [4:0]                   blue
);

    video_pkg::rgb_t              palette [video_pkg::pal_entries];
    video_pkg::bus_region_e       region;
    logic                         pal_we;
    logic [video_pkg::h_bits-1:0] hcount_d;
    logic [video_pkg::v_bits-1:0] vcount_d;
    logic                         lhbl_d;
    logic                         lvbl_d;
    video_pkg::rgb_t              colour;

    assign region = video_pkg::bus_region_e'(bus.addr[7:6]);
    assign pal_we = bus.we && (region == video_pkg::region_palette)
                    && (bus.addr[5:0] < video_pkg::pal_entries);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < video_pkg::pal_entries; i++) begin
                palette[i] <= '0;
            end
        end else if (pal_we) begin
            palette[bus.addr[3:0]] <= bus.data[14:0];
        end
    end

    // Tile over background, black outside the active area
    always_comb begin
        colour = tile_pxl.opaque ? palette[tile_pxl.index] : bg_colour;
        if (!lhbl_d || !lvbl_d) begin
            colour = '0;
        end
    end

    // First stage lines the raster up with tile_pxl, second with the colour
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount_d <= '0;
            vcount_d <= '0;
            lhbl_d   <= 1'b1;
            lvbl_d   <= 1'b1;
            hdump    <= '0;
            vdump    <= '0;
            lhbl     <= 1'b1;
            lvbl     <= 1'b1;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else begin
            hcount_d <= raster.hcount;
            vcount_d <= raster.vcount;
            lhbl_d   <= raster.lhbl;
            lvbl_d   <= raster.lvbl;
            hdump    <= hcount_d;
            vdump    <= vcount_d;
            lhbl     <= lhbl_d;
            lvbl     <= lvbl_d;
            red      <= colour.r;
            green    <= colour.g;
            blue     <= colour.b;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu_bus_if.sv
// CPU write bus
// Single-cycle write strobe with address and data, no read-back
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;

    logic [7:0]  addr;
    logic [15:0] data;
    logic        we;

    // Blocks that own storage decode their own region
    modport receiver (
        input addr,
        input data,
        input we
    );

endinterface

`default_nettype wire

//--- hdl/raster_if.sv
// Beam position and blanking from the timing generator
`timescale 1ns/1ps
`default_nettype none

interface raster_if;

    logic [video_pkg::h_bits-1:0] hcount;
    logic [video_pkg::v_bits-1:0] vcount;
    logic                         lhbl;
    logic                         lvbl;

    modport source (
        output hcount, vcount, lhbl, lvbl
    );

    modport sink (
        input hcount, vcount, lhbl, lvbl
    );

endinterface

`default_nettype wire

//--- hdl/tile_layer.sv
// Tile layer
// Holds the tile map and looks up one entry per pixel, with
// horizontal scroll wrapping at the 64-pixel map width
`timescale 1ns/1ps
`default_nettype none

module tile_layer (
    input  logic                         clk,
    input  logic                         rst,
    cpu_bus_if.receiver                  bus,
    raster_if.sink                       raster,
    input  logic                         layer_en,
    input  logic [video_pkg::h_bits-1:0] scroll,
    output video_pkg::map_entry_t        tile_pxl
);

    video_pkg::map_entry_t        tile_map [video_pkg::map_entries];
    video_pkg::bus_region_e       region;
    logic                         map_we;
    logic [video_pkg::h_bits-1:0] hpos;
    logic [2:0]                   tile_col;
    logic [1:0]                   tile_row;
    logic [4:0]                   map_idx;
    video_pkg::map_entry_t        entry;

    // Write decode, offset is row * map_cols + column
    assign region = video_pkg::bus_region_e'(bus.addr[7:6]);
    assign map_we = bus.we && (region == video_pkg::region_map)
                    && (bus.addr[5:0] < video_pkg::map_entries);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < video_pkg::map_entries; i++) begin
                tile_map[i] <= '0;
            end
        end else if (map_we) begin
            tile_map[bus.addr[4:0]] <= bus.data[4:0];
        end
    end

    // Scrolled position wraps naturally in 6 bits
    assign hpos     = raster.hcount + scroll;
    assign tile_col = 3'(hpos / video_pkg::tile_size);
    assign tile_row = 2'(raster.vcount / video_pkg::tile_size);
    assign map_idx  = 5'(tile_row * video_pkg::map_cols + tile_col);

    // Rows below the map fall in vertical blank
    always_comb begin
        entry = '0;
        if (map_idx < video_pkg::map_entries) begin
            entry = tile_map[map_idx];
        end
    end

    always_ff @(posedge clk) begin
        tile_pxl.index  <= entry.index;
        tile_pxl.opaque <= entry.opaque && layer_en;
    end

endmodule

`default_nettype wire

//--- hdl/video_pkg.sv
// Video subsystem shared definitions
// Raster geometry, CPU address map and register encodings
`default_nettype none

package video_pkg;

    // Shrunk raster, one pixel per clock
    localparam int h_active     = 32;
    localparam int h_total      = 40;
    localparam int h_sync_start = 34;
    localparam int h_sync_end   = 37;
    localparam int v_active     = 24;
    localparam int v_total      = 28;
    localparam int v_sync_start = 25;
    localparam int v_sync_end   = 26;
    localparam int h_bits       = 6;
    localparam int v_bits       = 5;

    // Tile map is 64 pixels wide, scroll wraps there
    localparam int tile_size   = 8;
    localparam int map_cols    = 8;
    localparam int map_rows    = 3;
    localparam int map_entries = map_cols * map_rows;
    localparam int pal_entries = 16;

    typedef struct packed {
        logic       opaque;
        logic [3:0] index;
    } map_entry_t;

    typedef struct packed {
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } rgb_t;

    // Region comes from cpu address bits 7:6
    typedef enum logic [1:0] {
        region_regs    = 2'd0,
        region_palette = 2'd1,
        region_map     = 2'd2,
        region_unused  = 2'd3
    } bus_region_e;

    typedef enum logic [5:0] {
        reg_ctrl   = 6'd0,
        reg_scroll = 6'd1,
        reg_bg     = 6'd2,
        reg_line   = 6'd3
    } reg_addr_e;

endpackage

`default_nettype wire

//--- hdl/video_regs.sv
// Video control registers
// Layer enable, horizontal scroll, background colour and the
// line interrupt target, all written from the CPU bus
`timescale 1ns/1ps
`default_nettype none

module video_regs (
    input  logic                         clk,
    input  logic                         rst,
    cpu_bus_if.receiver                  bus,
    output logic                         layer_en,
    output logic [video_pkg::h_bits-1:0] scroll,
    output video_pkg::rgb_t              bg_colour,
    output logic [video_pkg::v_bits-1:0] int_line
);

    video_pkg::bus_region_e region;
    video_pkg::reg_addr_e   offset;
    logic                   reg_we;

    assign region = video_pkg::bus_region_e'(bus.addr[7:6]);
    assign offset = video_pkg::reg_addr_e'(bus.addr[5:0]);
    assign reg_we = bus.we && (region == video_pkg::region_regs);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_en  <= 1'b0;
            scroll    <= '0;
            bg_colour <= '0;
            int_line  <= '0;
        end else if (reg_we) begin
            case (offset)
                video_pkg::reg_ctrl:   layer_en  <= bus.data[0];
                video_pkg::reg_scroll: scroll    <= bus.data[video_pkg::h_bits-1:0];
                // Red in the top bits, as 5:5:5
                video_pkg::reg_bg:     bg_colour <= bus.data[14:0];
                video_pkg::reg_line:   int_line  <= bus.data[video_pkg::v_bits-1:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/video_timing.sv
// Video timing generator
// Beam counters, sync and blanking, vertical and line interrupts.
// All outputs are registered and aligned with the counters.
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  logic                         clk,
    input  logic                         rst,
    raster_if.source                     raster,
    input  logic [video_pkg::v_bits-1:0] int_line,
    output logic                         hs,
    output logic                         vs,
    output logic                         vint,
    output logic                         line_intn
);

    logic [video_pkg::h_bits-1:0] h_next;
    logic [video_pkg::v_bits-1:0] v_next;
    logic                         h_wrap;

    // Next beam position
    always_comb begin
        h_wrap = raster.hcount == video_pkg::h_bits'(video_pkg::h_total - 1);
        h_next = h_wrap ? '0 : raster.hcount + 1'b1;
        v_next = raster.vcount;
        if (h_wrap) begin
            if (raster.vcount == video_pkg::v_bits'(video_pkg::v_total - 1))
                v_next = '0;
            else
                v_next = raster.vcount + 1'b1;
        end
    end

    // Decode from the next position so flags line up with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster.hcount <= '0;
            raster.vcount <= '0;
            raster.lhbl   <= 1'b1;
            raster.lvbl   <= 1'b1;
            hs            <= 1'b0;
            vs            <= 1'b0;
            vint          <= 1'b0;
            line_intn     <= 1'b1;
        end else begin
            raster.hcount <= h_next;
            raster.vcount <= v_next;
            raster.lhbl   <= h_next < video_pkg::h_active;
            raster.lvbl   <= v_next < video_pkg::v_active;
            hs <= (h_next >= video_pkg::h_sync_start) && (h_next < video_pkg::h_sync_end);
            vs <= (v_next >= video_pkg::v_sync_start) && (v_next < video_pkg::v_sync_end);
            // One pulse at the start of vertical blank
            vint      <= (v_next == video_pkg::v_active) && (h_next == '0);
            line_intn <= v_next != int_line;
        end
    end

endmodule

`default_nettype wire

//--- hdl/video_top.sv
// Raster video subsystem top level
// CPU write bus in, sync, blanking, interrupts and 5:5:5 RGB out
`timescale 1ns/1ps
`default_nettype none

module video_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [7:0]                   cpu_addr,
    input  logic [15:0]                  cpu_data,
    input  logic                         cpu_we,
    output logic                         hs,
    output logic                         vs,
    output logic                         lhbl,
    output logic                         lvbl,
    output logic [video_pkg::h_bits-1:0] hdump,
    output logic [video_pkg::v_bits-1:0] vdump,
    output logic                         vint,
    output logic                         line_intn,
    output logic [4:0]                   red,
    output logic [4:0]                   green,
    output logic [4:0]                   blue
);

    cpu_bus_if bus ();
    raster_if  raster ();

    logic                         layer_en;
    logic [video_pkg::h_bits-1:0] scroll;
    video_pkg::rgb_t              bg_colour;
    logic [video_pkg::v_bits-1:0] int_line;
    video_pkg::map_entry_t        tile_pxl;

    assign bus.addr = cpu_addr;
    assign bus.data = cpu_data;
    assign bus.we   = cpu_we;

    video_timing u_timing (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .raster    ( raster    ),
        .int_line  ( int_line  ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .vint      ( vint      ),
        .line_intn ( line_intn )
    );

    video_regs u_regs (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus       ( bus       ),
        .layer_en  ( layer_en  ),
        .scroll    ( scroll    ),
        .bg_colour ( bg_colour ),
        .int_line  ( int_line  )
    );

    tile_layer u_tile (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .bus      ( bus      ),
        .raster   ( raster   ),
        .layer_en ( layer_en ),
        .scroll   ( scroll   ),
        .tile_pxl ( tile_pxl )
    );

    colour_mixer u_mixer (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus       ( bus       ),
        .raster    ( raster    ),
        .tile_pxl  ( tile_pxl  ),
        .bg_colour ( bg_colour ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

endmodule

`default_nettype wire

//--- sources.f
hdl/video_pkg.sv
hdl/cpu_bus_if.sv
hdl/raster_if.sv
hdl/video_timing.sv
hdl/video_regs.sv
hdl/tile_layer.sv
hdl/colour_mixer.sv
hdl/video_top.sv
dv/video_props.sv
dv/video_tb.sv
